/* source/uart_dbg_settings.svh */
`ifndef UART_DBG_SETTINGS_SVH
`define UART_DBG_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Bit timing
//////////////////////////////////////////////////////////////////////

// Clock cycles per UART bit
`define UART_DBG_CLKS_PER_BIT 16

//////////////////////////////////////////////////////////////////////
// Memory and protocol
//////////////////////////////////////////////////////////////////////

`define UART_DBG_MEM_DEPTH 256
`define UART_DBG_ADDR_BITS 8

// Command and reply bytes
`define UART_DBG_CMD_READ  8'h11
`define UART_DBG_CMD_WRITE 8'h12
`define UART_DBG_ACK       8'h06
`define UART_DBG_EOT       8'h04

`endif

/* source/uart_dbg_pkg.sv */
`include "uart_dbg_settings.svh"

package uart_dbg_pkg;

  // One byte on the wire or in memory
  typedef logic [7:0] byte_t;

  // Index into the byte memory, upper address bits are dropped
  typedef logic [`UART_DBG_ADDR_BITS-1:0] mem_addr_t;

  // Transfer length, full 64 bits as received
  typedef logic [63:0] dbg_len_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } dbg_op_e;

  // Decoded command header
  typedef struct packed {
    dbg_op_e   op;
    mem_addr_t addr;
    dbg_len_t  len;
  } dbg_cmd_t;

  // One read data beat
  typedef struct packed {
    byte_t data;
    logic  last;
  } rd_beat_t;

endpackage

/* source/uart_dbg_rx.sv */
`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_dbg_rx (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_byte_o
);

  localparam int unsigned CLKS  = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned CNT_W = $clog2(CLKS);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e           state_q;
  logic [1:0]          sync_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [2:0]          bit_q;
  logic                valid_q;
  uart_dbg_pkg::byte_t shift_q;
  logic                line;
  logic                bit_end;
  logic                half_end;

  assign line     = sync_q[1];
  assign bit_end  = (cnt_q == CNT_W'(CLKS - 1));
  assign half_end = (cnt_q == CNT_W'(CLKS / 2 - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= RX_IDLE;
      sync_q  <= 2'b11;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (!line) begin
            state_q <= RX_START;
            cnt_q   <= '0;
          end
        end
        // Recheck the start bit at its middle and fall back to idle on a glitch
        RX_START: begin
          if (half_end) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= line ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            cnt_q   <= '0;
            state_q <= RX_IDLE;
            valid_q <= line;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

  // A frame must end with a high stop bit
  a_rx_stop_bit : assert property (
    @(posedge clk) disable iff (!rst_n_i) (state_q == RX_STOP && bit_end) |-> line
  );

endmodule

/* source/uart_dbg_tx.sv */
`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_dbg_tx (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                tx_start_i,
  input  uart_dbg_pkg::byte_t tx_byte_i,
  output logic                tx_busy_o,
  output logic                tx_o
);

  localparam int unsigned CLKS  = `UART_DBG_CLKS_PER_BIT;
  localparam int unsigned CNT_W = $clog2(CLKS);

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [3:0]       bit_q;
  logic             tx_q;
  logic [7:0]       frame_q;
  logic             bit_end;

  assign bit_end = (cnt_q == CNT_W'(CLKS - 1));

  // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      bit_q  <= '0;
      tx_q   <= 1'b1;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
        bit_q  <= '0;
        tx_q   <= 1'b0;
      end
    end else if (bit_end) begin
      cnt_q <= '0;
      if (bit_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
        tx_q  <= frame_q[0];
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Data bits with ones shifting in behind for the stop bit
  always_ff @(posedge clk) begin
    if (!busy_q && tx_start_i) begin
      frame_q <= tx_byte_i;
    end else if (busy_q && bit_end) begin
      frame_q <= {1'b1, frame_q[7:1]};
    end
  end

  assign tx_busy_o = busy_q;
  assign tx_o      = tx_q;

  a_tx_no_start_busy : assert property (
    @(posedge clk) disable iff (!rst_n_i) tx_busy_o |-> !tx_start_i
  );

endmodule

/* source/uart_dbg_decode.sv */
`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_dbg_decode (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   rx_valid_i,
  input  uart_dbg_pkg::byte_t    rx_byte_i,
  input  logic                   op_done_i,
  output logic                   ping_o,
  output logic                   cmd_valid_o,
  output uart_dbg_pkg::dbg_cmd_t cmd_o,
  output logic                   wr_valid_o,
  output uart_dbg_pkg::byte_t    wr_byte_o
);

  typedef enum logic [2:0] {
    DEC_IDLE, DEC_ADDR, DEC_LEN, DEC_DATA, DEC_WAIT
  } dec_state_e;

  dec_state_e              state_q;
  logic [2:0]              cnt_q;
  logic                    ping_q;
  logic                    cmd_valid_q;
  logic                    wr_valid_q;
  uart_dbg_pkg::dbg_op_e   op_q;
  uart_dbg_pkg::mem_addr_t addr_q;
  uart_dbg_pkg::dbg_len_t  len_q;
  uart_dbg_pkg::byte_t     wr_byte_q;

  //////////////////////////////////////////////////////////////////////
  // Header FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= DEC_IDLE;
      cnt_q       <= '0;
      ping_q      <= 1'b0;
      cmd_valid_q <= 1'b0;
      wr_valid_q  <= 1'b0;
    end else begin
      ping_q      <= 1'b0;
      cmd_valid_q <= 1'b0;
      wr_valid_q  <= 1'b0;
      case (state_q)
        // Unknown bytes are dropped here without a reply
        DEC_IDLE: begin
          if (rx_valid_i) begin
            if (rx_byte_i == `UART_DBG_ACK) begin
              ping_q <= 1'b1;
            end else if (rx_byte_i == `UART_DBG_CMD_READ ||
                         rx_byte_i == `UART_DBG_CMD_WRITE) begin
              state_q <= DEC_ADDR;
              cnt_q   <= '0;
            end
          end
        end
        DEC_ADDR: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 3'd7) begin
              state_q <= DEC_LEN;
            end
          end
        end
        DEC_LEN: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 3'd7) begin
              cmd_valid_q <= 1'b1;
              state_q     <= (op_q == uart_dbg_pkg::OP_WRITE) ? DEC_DATA : DEC_WAIT;
            end
          end
        end
        DEC_DATA: begin
          if (op_done_i) begin
            state_q <= DEC_IDLE;
          end else if (rx_valid_i) begin
            wr_valid_q <= 1'b1;
          end
        end
        DEC_WAIT: begin
          if (op_done_i) begin
            state_q <= DEC_IDLE;
          end
        end
        default: state_q <= DEC_IDLE;
      endcase
    end
  end

  // Header fields, LSB first; only byte 0 of the address is kept
  always_ff @(posedge clk) begin
    if (state_q == DEC_IDLE && rx_valid_i) begin
      op_q <= (rx_byte_i == `UART_DBG_CMD_WRITE) ? uart_dbg_pkg::OP_WRITE
                                                  : uart_dbg_pkg::OP_READ;
    end
    if (state_q == DEC_ADDR && rx_valid_i && cnt_q == 3'd0) begin
      addr_q <= uart_dbg_pkg::mem_addr_t'(rx_byte_i);
    end
    if (state_q == DEC_LEN && rx_valid_i) begin
      len_q[8*cnt_q +: 8] <= rx_byte_i;
    end
    if (state_q == DEC_DATA && rx_valid_i) begin
      wr_byte_q <= rx_byte_i;
    end
  end

  assign ping_o      = ping_q;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = '{op: op_q, addr: addr_q, len: len_q};
  assign wr_valid_o  = wr_valid_q;
  assign wr_byte_o   = wr_byte_q;

endmodule

/* source/uart_dbg_execute.sv */
`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_dbg_execute (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  input  uart_dbg_pkg::dbg_cmd_t cmd_i,
  input  logic                   wr_valid_i,
  input  uart_dbg_pkg::byte_t    wr_byte_i,
  input  logic                   rd_next_i,
  output logic                   rd_valid_o,
  output uart_dbg_pkg::rd_beat_t rd_beat_o,
  output logic                   op_done_o
);

  uart_dbg_pkg::byte_t     mem_q [`UART_DBG_MEM_DEPTH];
  uart_dbg_pkg::mem_addr_t addr_q;
  uart_dbg_pkg::dbg_len_t  remain_q;
  logic                    rd_valid_q;
  logic                    done_q;
  uart_dbg_pkg::byte_t     rd_data_q;
  logic                    rd_last_q;
  logic                    last_beat;

  assign last_beat = (remain_q == uart_dbg_pkg::dbg_len_t'(1));

  // Address wraps at the memory size
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      addr_q     <= '0;
      remain_q   <= '0;
      rd_valid_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      rd_valid_q <= rd_next_i;
      done_q     <= 1'b0;
      if (cmd_valid_i) begin
        addr_q   <= cmd_i.addr;
        remain_q <= cmd_i.len;
        done_q   <= (cmd_i.len == '0);
      end else if (wr_valid_i || rd_next_i) begin
        addr_q   <= addr_q + 1'b1;
        remain_q <= remain_q - 1'b1;
        done_q   <= rd_next_i && last_beat;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid_i) begin
      mem_q[addr_q] <= wr_byte_i;
    end
    if (rd_next_i) begin
      rd_data_q <= mem_q[addr_q];
      rd_last_q <= last_beat;
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_beat_o  = '{data: rd_data_q, last: rd_last_q};
  // Last write completes in the cycle of its store
  assign op_done_o  = done_q | (wr_valid_i & last_beat);

  a_exe_no_rw_overlap : assert property (
    @(posedge clk) disable iff (!rst_n_i) !(wr_valid_i && rd_next_i)
  );

endmodule

/* source/uart_dbg_result.sv */
`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_dbg_result (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   ping_i,
  input  logic                   cmd_valid_i,
  input  uart_dbg_pkg::dbg_cmd_t cmd_i,
  input  logic                   rd_valid_i,
  input  uart_dbg_pkg::rd_beat_t rd_beat_i,
  input  logic                   op_done_i,
  input  logic                   tx_busy_i,
  output logic                   rd_next_o,
  output logic                   tx_start_o,
  output uart_dbg_pkg::byte_t    tx_byte_o
);

  typedef enum logic [2:0] {
    RES_IDLE, RES_ACK, RES_FETCH, RES_SEND, RES_WAIT_DONE, RES_EOT
  } res_state_e;

  res_state_e          state_q;
  logic                ping_only_q;
  logic                stream_q;
  logic                done_seen_q;
  logic                loaded_q;
  logic                last_q;
  uart_dbg_pkg::byte_t pend_q;
  logic                fire;

  // Start a byte only while the transmitter is idle
  always_comb begin
    case (state_q)
      RES_ACK, RES_EOT: fire = !tx_busy_i;
      RES_SEND:         fire = loaded_q && !tx_busy_i;
      default:          fire = 1'b0;
    endcase
  end

  always_comb begin
    case (state_q)
      RES_SEND: tx_byte_o = pend_q;
      RES_EOT:  tx_byte_o = `UART_DBG_EOT;
      default:  tx_byte_o = `UART_DBG_ACK;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= RES_IDLE;
      ping_only_q <= 1'b0;
      stream_q    <= 1'b0;
      done_seen_q <= 1'b0;
      loaded_q    <= 1'b0;
      last_q      <= 1'b0;
    end else begin
      // op_done may come while ACK is still waiting for the line
      if (op_done_i) begin
        done_seen_q <= 1'b1;
      end
      case (state_q)
        RES_IDLE: begin
          if (cmd_valid_i) begin
            ping_only_q <= 1'b0;
            stream_q    <= (cmd_i.op == uart_dbg_pkg::OP_READ) && (cmd_i.len != '0);
            done_seen_q <= 1'b0;
            state_q     <= RES_ACK;
          end else if (ping_i) begin
            ping_only_q <= 1'b1;
            state_q     <= RES_ACK;
          end
        end
        RES_ACK: begin
          if (fire) begin
            state_q <= ping_only_q ? RES_IDLE : (stream_q ? RES_FETCH : RES_WAIT_DONE);
          end
        end
        RES_FETCH: begin
          loaded_q <= 1'b0;
          state_q  <= RES_SEND;
        end
        RES_SEND: begin
          if (rd_valid_i) begin
            loaded_q <= 1'b1;
            last_q   <= rd_beat_i.last;
          end else if (fire) begin
            loaded_q <= 1'b0;
            state_q  <= last_q ? RES_EOT : RES_FETCH;
          end
        end
        RES_WAIT_DONE: begin
          if (done_seen_q || op_done_i) begin
            state_q <= RES_EOT;
          end
        end
        RES_EOT: begin
          if (fire) begin
            state_q <= RES_IDLE;
          end
        end
        default: state_q <= RES_IDLE;
      endcase
    end
  end

  // Pending read byte
  always_ff @(posedge clk) begin
    if (state_q == RES_SEND && rd_valid_i) begin
      pend_q <= rd_beat_i.data;
    end
  end

  assign rd_next_o  = (state_q == RES_FETCH);
  assign tx_start_o = fire;

endmodule

/* source/uart_dbg_top.sv */
`timescale 1ns/1ps

module uart_dbg_top (
  input  logic clk,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  logic                   rx_valid;
  uart_dbg_pkg::byte_t    rx_byte;
  logic                   ping;
  logic                   cmd_valid;
  uart_dbg_pkg::dbg_cmd_t cmd;
  logic                   wr_valid;
  uart_dbg_pkg::byte_t    wr_byte;
  logic                   op_done;
  logic                   rd_next;
  logic                   rd_valid;
  uart_dbg_pkg::rd_beat_t rd_beat;
  logic                   tx_start;
  uart_dbg_pkg::byte_t    tx_byte;
  logic                   tx_busy;

  //////////////////////////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////////////////////////

  uart_dbg_rx u_rx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   )
  );

  uart_dbg_decode u_decode (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .rx_valid_i  ( rx_valid  ),
    .rx_byte_i   ( rx_byte   ),
    .op_done_i   ( op_done   ),
    .ping_o      ( ping      ),
    .cmd_valid_o ( cmd_valid ),
    .cmd_o       ( cmd       ),
    .wr_valid_o  ( wr_valid  ),
    .wr_byte_o   ( wr_byte   )
  );

  uart_dbg_execute u_execute (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .cmd_valid_i ( cmd_valid ),
    .cmd_i       ( cmd       ),
    .wr_valid_i  ( wr_valid  ),
    .wr_byte_i   ( wr_byte   ),
    .rd_next_i   ( rd_next   ),
    .rd_valid_o  ( rd_valid  ),
    .rd_beat_o   ( rd_beat   ),
    .op_done_o   ( op_done   )
  );

  //////////////////////////////////////////////////////////////////////
  // Reply path
  //////////////////////////////////////////////////////////////////////

  uart_dbg_result u_result (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .ping_i      ( ping      ),
    .cmd_valid_i ( cmd_valid ),
    .cmd_i       ( cmd       ),
    .rd_valid_i  ( rd_valid  ),
    .rd_beat_i   ( rd_beat   ),
    .op_done_i   ( op_done   ),
    .tx_busy_i   ( tx_busy   ),
    .rd_next_o   ( rd_next   ),
    .tx_start_o  ( tx_start  ),
    .tx_byte_o   ( tx_byte   )
  );

  uart_dbg_tx u_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_start_i ( tx_start  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_busy_o  ( tx_busy   ),
    .tx_o       ( uart_tx_o )
  );

endmodule

/* verification/tb_uart_dbg.sv */
`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module tb_uart_dbg;

  localparam int unsigned CLKS = `UART_DBG_CLKS_PER_BIT;

  // Bytes sent and received per test with quiet waits counted as bytes
  // ping, write and read back, wrap, upper bits, zero length, unknown command
  localparam int unsigned TEST_BYTES  = 4 + 54 + 65 + 23 + 40 + 5;
  localparam int unsigned CYCLE_LIMIT = TEST_BYTES * 10 * CLKS * 3 / 2;

  // Longest wait for a single reply byte
  localparam int unsigned REPLY_WAIT = 30 * CLKS;

  logic clk;
  logic rst_n_i;
  logic uart_rx_i;
  logic uart_tx_o;

  uart_dbg_pkg::byte_t rx_q [$];
  uart_dbg_pkg::byte_t model_mem [`UART_DBG_MEM_DEPTH];
  logic [31:0]         lfsr_q;
  int unsigned         cycles = 0;
  int                  err_count = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;

  uart_dbg_top u_uart_dbg_top (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .uart_rx_i ( uart_rx_i ),
    .uart_tx_o ( uart_tx_o )
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and reply monitor
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output uart_dbg_pkg::byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      b[i]   = lfsr_q[0];
    end
  endtask

  // Start bit, 8 data bits LSB first, stop bit
  task automatic send_byte(input uart_dbg_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (CLKS - 1) @(posedge clk);
    end
  endtask

  task automatic send_command(input uart_dbg_pkg::byte_t cmd, input logic [63:0] addr,
                              input uart_dbg_pkg::dbg_len_t len);
    send_byte(cmd);
    for (int i = 0; i < 8; i++) begin
      send_byte(addr[8*i +: 8]);
    end
    for (int i = 0; i < 8; i++) begin
      send_byte(len[8*i +: 8]);
    end
  endtask

  // Samples uart_tx_o at mid-bit on falling clock edges
  always begin : tx_monitor
    uart_dbg_pkg::byte_t b;
    @(negedge uart_tx_o);
    repeat (CLKS / 2) @(negedge clk);
    if (uart_tx_o !== 1'b0) begin
      $display("Start bit on uart_tx_o did not hold until mid-bit");
      err_count++;
    end else begin
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS) @(negedge clk);
        b[i] = uart_tx_o;
      end
      repeat (CLKS) @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
        $display("Missing stop bit on uart_tx_o");
        err_count++;
      end
      rx_q.push_back(b);
    end
  end

  task automatic next_reply(output uart_dbg_pkg::byte_t b, output logic ok);
    int unsigned waited;
    waited = 0;
    while (rx_q.size() == 0 && waited < REPLY_WAIT) begin
      @(negedge clk);
      waited++;
    end
    ok = (rx_q.size() != 0);
    b  = '0;
    if (ok) begin
      b = rx_q.pop_front();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input uart_dbg_pkg::byte_t got,
                            input uart_dbg_pkg::byte_t exp);
    if (got !== exp) begin
      $display("[FAIL] uart_tx_o %s: got 0x%h, expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_len(input string name, input uart_dbg_pkg::dbg_len_t got,
                           input uart_dbg_pkg::dbg_len_t exp);
    if (got !== exp) begin
      $display("[FAIL] uart_tx_o %s: got 0x%h, expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic expect_reply(input string name, input uart_dbg_pkg::byte_t exp);
    uart_dbg_pkg::byte_t got;
    logic                ok;
    next_reply(got, ok);
    if (!ok) begin
      $display("No %s byte on uart_tx_o within %0d cycles", name, REPLY_WAIT);
      err_count++;
    end else begin
      check_byte(name, got, exp);
    end
  endtask

  // Line must stay high and nothing may arrive
  task automatic quiet_line(input int unsigned n, input string what);
    logic low_seen;
    low_seen = 1'b0;
    repeat (n) begin
      @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
        low_seen = 1'b1;
      end
    end
    if (low_seen || rx_q.size() != 0) begin
      $display("Unexpected reply on uart_tx_o after %s", what);
      err_count++;
      rx_q.delete();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory access
  //////////////////////////////////////////////////////////////////////

  task automatic write_mem(input logic [63:0] addr, input uart_dbg_pkg::byte_t data [$]);
    int unsigned idx;
    send_command(`UART_DBG_CMD_WRITE, addr, uart_dbg_pkg::dbg_len_t'(data.size()));
    foreach (data[i]) begin
      send_byte(data[i]);
      // Only the address modulo the memory size selects a byte
      idx = int'((addr + 64'(i)) % `UART_DBG_MEM_DEPTH);
      model_mem[idx] = data[i];
    end
    expect_reply("write ack", `UART_DBG_ACK);
    expect_reply("write eot", `UART_DBG_EOT);
  endtask

  task automatic read_mem(input logic [63:0] addr, input int unsigned len);
    uart_dbg_pkg::byte_t got [$];
    uart_dbg_pkg::byte_t b;
    logic                ok;
    int unsigned         idx;
    send_command(`UART_DBG_CMD_READ, addr, uart_dbg_pkg::dbg_len_t'(len));
    expect_reply("read ack", `UART_DBG_ACK);
    ok = 1'b1;
    while (ok && got.size() < len) begin
      next_reply(b, ok);
      if (ok) begin
        got.push_back(b);
      end
    end
    check_len("read byte count", uart_dbg_pkg::dbg_len_t'(got.size()),
              uart_dbg_pkg::dbg_len_t'(len));
    foreach (got[i]) begin
      idx = int'((addr + 64'(i)) % `UART_DBG_MEM_DEPTH);
      check_byte($sformatf("read data at 0x%02h", idx), got[i], model_mem[idx]);
    end
    if (ok) begin
      expect_reply("read eot", `UART_DBG_EOT);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic ping_check();
    int start;
    start = err_count;
    send_byte(`UART_DBG_ACK);
    expect_reply("ping ack", `UART_DBG_ACK);
    quiet_line(12 * CLKS, "the ping reply");
    report_test("ack challenge", start);
  endtask

  task automatic write_read_back();
    uart_dbg_pkg::byte_t data [$];
    uart_dbg_pkg::byte_t b;
    int                  start;
    start = err_count;
    repeat (8) begin
      rand_byte(b);
      data.push_back(b);
    end
    write_mem(64'h10, data);
    read_mem(64'h10, 8);
    report_test("write then read back", start);
  endtask

  task automatic address_wrap();
    uart_dbg_pkg::byte_t data [$];
    uart_dbg_pkg::byte_t b;
    int                  start;
    start = err_count;
    repeat (4) begin
      rand_byte(b);
      data.push_back(b);
    end
    write_mem(64'hfe, data);
    read_mem(64'h00, 2);
    read_mem(64'hfe, 2);
    report_test("address wrap", start);
  endtask

  task automatic upper_addr_ignored();
    int start;
    start = err_count;
    read_mem(64'h0000_0001_0000_0010, 4);
    report_test("upper address bits", start);
  endtask

  task automatic zero_length();
    uart_dbg_pkg::byte_t none [$];
    int                  start;
    start = err_count;
    read_mem(64'h20, 0);
    write_mem(64'h20, none);
    send_byte(`UART_DBG_ACK);
    expect_reply("ping ack after zero length", `UART_DBG_ACK);
    report_test("zero length", start);
  endtask

  task automatic unknown_cmd();
    int start;
    start = err_count;
    send_byte(8'h55);
    quiet_line(20 * CLKS, "an unknown command");
    send_byte(`UART_DBG_ACK);
    expect_reply("ping ack after unknown command", `UART_DBG_ACK);
    report_test("unknown command", start);
  endtask

  initial begin
    uart_rx_i = 1'b1;
    rst_n_i   = 1'b0;
    lfsr_q    = 32'hf06b_190c;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge clk);

    ping_check();
    write_read_back();
    address_wrap();
    upper_addr_ignored();
    zero_length();
    unknown_cmd();

    $display("Tests run %0d, failed %0d, failed checks %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+source
source/uart_dbg_pkg.sv
source/uart_dbg_rx.sv
source/uart_dbg_tx.sv
source/uart_dbg_decode.sv
source/uart_dbg_execute.sv
source/uart_dbg_result.sv
source/uart_dbg_top.sv
verification/tb_uart_dbg.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_uart_dbg
FILELIST   := vlog.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
